// File: exec_alu.f
verilog/exec_alu_pkg.sv
verilog/shift_add_multiplier.sv
verilog/operand_select.sv
verilog/alu_core.sv
verilog/result_port.sv
verilog/exec_alu_top.sv
sim/tb_exec_alu.sv

// File: sim/tb_exec_alu.sv
module tb_exec_alu
    import exec_alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [xlen-1:0] ones = '1;
    localparam logic [xlen-1:0] smin = {1'b1, {(xlen-1){1'b0}}};
    localparam int wait_limit = 200;

    // one stimulus row; fixed rows use a and b in place of random words
    typedef struct packed {
        alu_op_t         op;
        src_a_t          src_a;
        src_b_t          src_b;
        logic            word;
        logic            fixed;
        logic            do_flush;
        logic [3:0]      delay;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } row_t;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            flush;
    logic            issue_req;
    alu_issue_t      issue;
    logic            issue_ack;
    logic            res_req;
    logic [xlen-1:0] res_data;
    logic            res_ack;

    row_t            rows[$];
    logic [xlen-1:0] exp_q[$];
    logic [15:0]     lfsr = 16'd7;
    int              value_errors = 0;
    int              protocol_errors = 0;
    logic            ack_p = 1'b0;
    logic            req_p = 1'b0;
    logic            rreq_p = 1'b0;
    logic            rack_p = 1'b0;

    exec_alu_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .issue_req (issue_req),
        .issue     (issue),
        .issue_ack (issue_ack),
        .res_req   (res_req),
        .res_data  (res_data),
        .res_ack   (res_ack)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [xlen-1:0] rand_word();
        logic [xlen-1:0] v;
        v = '0;
        for (int i = 0; i < xlen; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[xlen-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // reference model of the execute unit
    function automatic logic [xlen-1:0] expected_result(input alu_issue_t r);
        logic [xlen-1:0]        a;
        logic [xlen-1:0]        b;
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [95:0]            ext_w;
        logic [2*xlen-1:0]      ext_d;
        logic [xlen-1:0]        q_s;
        logic [xlen-1:0]        r_s;
        logic                   by_zero;
        logic                   overflow;
        if (r.src_a == src_a_pc) begin
            a = r.pc;
        end else begin
            a = r.word ? {32'h0, r.rs1[31:0]} : r.rs1;
        end
        case (r.src_b)
            src_b_rs2: b = r.rs2;
            src_b_csr: b = r.csr;
            default:   b = r.imm;
        endcase
        sa = a;
        sb = b;
        // arithmetic shifts as logical shifts of the sign-extended value
        ext_w = {{64{a[31]}}, a[31:0]} >> b[5:0];
        ext_d = {{xlen{a[xlen-1]}}, a} >> b[5:0];
        by_zero = (b == '0);
        overflow = (a == smin) && (b == ones);
        if (by_zero || overflow) begin
            q_s = '0;
            r_s = '0;
        end else begin
            q_s = sa / sb;
            r_s = sa % sb;
        end
        case (r.op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << b[5:0];
            op_srl:    return a >> b[5:0];
            op_sra:    return r.word ? {32'h0, ext_w[31:0]} : ext_d[xlen-1:0];
            op_slt:    return {63'h0, sa < sb};
            op_sltu:   return {63'h0, a < b};
            op_eq:     return {63'h0, a == b};
            op_ge:     return {63'h0, sa >= sb};
            op_geu:    return {63'h0, a >= b};
            op_mul:    return a * b;
            op_div:    return by_zero ? ones : (overflow ? a : q_s);
            op_divu:   return by_zero ? ones : a / b;
            op_rem:    return by_zero ? a : (overflow ? '0 : r_s);
            op_remu:   return by_zero ? a : a % b;
            default:   return '0;
        endcase
    endfunction

    task automatic add_row(input alu_op_t op, input src_a_t sa, input src_b_t sb,
                           input logic word, input logic fixed, input logic fl,
                           input int delay, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b);
        rows.push_back(row_t'{op, sa, sb, word, fixed, fl, 4'(delay), a, b});
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // raise issue_req with a fresh record and queue its expected result
    task automatic present(input row_t r);
        alu_issue_t rec;
        rec.pc    = r.fixed ? r.a : rand_word();
        rec.rs1   = r.fixed ? r.a : rand_word();
        rec.rs2   = r.fixed ? r.b : rand_word();
        rec.csr   = r.fixed ? r.b : rand_word();
        rec.imm   = r.fixed ? r.b : rand_word();
        rec.op    = r.op;
        rec.src_a = r.src_a;
        rec.src_b = r.src_b;
        rec.word  = r.word;
        exp_q.push_back(expected_result(rec));
        issue     = rec;
        issue_req = 1'b1;
    endtask

    task automatic give_up(input string what);
        $display("Timeout: %s did not happen within %0d cycles at %0t", what,
                 wait_limit, $time);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // which selects issue_ack (0) or res_req (1)
    task automatic wait_level(input int which, input logic level, input string what);
        int cnt;
        cnt = 0;
        while (((which == 0) ? issue_ack : res_req) !== level) begin
            next_cycle();
            cnt++;
            if (cnt > wait_limit) give_up(what);
        end
    endtask

    task automatic check_data(input logic [xlen-1:0] expv);
        if (res_data !== expv) begin
            value_errors++;
            $display("Mismatch at %0t: res_data expected %h got %h", $time, expv, res_data);
        end
    endtask

    task automatic protocol_fail(input string msg);
        protocol_errors++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    // handshake order sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (issue_ack && !ack_p && !req_p) protocol_fail("issue_ack rose without issue_req");
            if (!issue_ack && ack_p && req_p) protocol_fail("issue_ack fell with issue_req high");
            if (issue_ack && !ack_p && (rreq_p || rack_p))
                protocol_fail("issue_ack rose while a result was still on offer");
            if (!res_req && rreq_p && !rack_p) protocol_fail("res_req fell before res_ack");
        end
        ack_p  = issue_ack;
        req_p  = issue_req;
        rreq_p = res_req;
        rack_p = res_ack;
    end

    task automatic build_table();
        add_row(op_add, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_sub, src_a_rs1, src_b_imm, 0, 0, 0, 0, '0, '0);
        add_row(op_pass_a, src_a_pc, src_b_csr, 0, 0, 0, 0, '0, '0);
        add_row(op_pass_b, src_a_rs1, src_b_csr, 0, 0, 0, 5, '0, '0);
        add_row(op_pass_b, src_a_pc, src_b_imm, 0, 0, 0, 0, '0, '0);
        add_row(op_xor, src_a_pc, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_or, src_a_rs1, src_b_csr, 0, 0, 0, 0, '0, '0);
        add_row(op_and, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_sll, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_srl, src_a_rs1, src_b_imm, 0, 0, 0, 0, '0, '0);
        add_row(op_sra, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_slt, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_sltu, src_a_pc, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_eq, src_a_rs1, src_b_rs2, 0, 1, 0, 0, 64'h1234, 64'h1234);
        add_row(op_ge, src_a_rs1, src_b_imm, 0, 0, 0, 0, '0, '0);
        add_row(op_geu, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_div, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_divu, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_rem, src_a_rs1, src_b_csr, 0, 0, 0, 0, '0, '0);
        add_row(op_remu, src_a_pc, src_b_rs2, 0, 0, 0, 0, '0, '0);
        // word mode
        add_row(op_add, src_a_rs1, src_b_imm, 1, 0, 0, 0, '0, '0);
        add_row(op_pass_a, src_a_pc, src_b_imm, 1, 0, 0, 0, '0, '0);
        add_row(op_sra, src_a_rs1, src_b_rs2, 1, 0, 0, 0, '0, '0);
        add_row(op_sra, src_a_rs1, src_b_rs2, 1, 1, 0, 0, 64'h8000_0000, 64'd4);
        // edge operands
        add_row(op_div, src_a_rs1, src_b_rs2, 0, 1, 0, 0, 64'd1234, '0);
        add_row(op_divu, src_a_rs1, src_b_rs2, 0, 1, 0, 0, ones, '0);
        add_row(op_rem, src_a_rs1, src_b_rs2, 0, 1, 0, 0, smin, '0);
        add_row(op_remu, src_a_rs1, src_b_rs2, 0, 1, 0, 0, 64'd99, '0);
        add_row(op_div, src_a_rs1, src_b_rs2, 0, 1, 0, 0, smin, ones);
        add_row(op_rem, src_a_rs1, src_b_rs2, 0, 1, 0, 0, smin, ones);
        add_row(op_sra, src_a_rs1, src_b_rs2, 0, 1, 0, 0, smin, 64'd63);
        add_row(op_slt, src_a_rs1, src_b_rs2, 0, 1, 0, 0, smin, '0);
        // multiply, back-pressure and flush
        add_row(op_mul, src_a_rs1, src_b_rs2, 0, 0, 0, 0, '0, '0);
        add_row(op_mul, src_a_pc, src_b_imm, 0, 0, 0, 8, '0, '0);
        add_row(op_mul, src_a_rs1, src_b_rs2, 0, 1, 0, 0, ones, ones);
        add_row(op_mul, src_a_rs1, src_b_rs2, 0, 1, 0, 12, smin, 64'd2);
        add_row(op_mul, src_a_rs1, src_b_rs2, 0, 0, 1, 0, '0, '0);
        add_row(op_sub, src_a_pc, src_b_csr, 0, 0, 0, 0, '0, '0);
    endtask

    initial begin
        row_t            r;
        logic [xlen-1:0] expv;
        logic            presented;
        int              k;
        arst_n    = 1'b0;
        flush     = 1'b0;
        issue_req = 1'b0;
        issue     = '0;
        res_ack   = 1'b0;
        presented = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        next_cycle();
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (!presented) present(r);
            presented = 1'b0;
            wait_level(0, 1'b1, "issue_ack rising");
            issue_req = 1'b0;
            wait_level(0, 1'b0, "issue_ack falling");
            expv = exp_q.pop_front();
            if (r.do_flush) begin
                repeat (5) next_cycle();
                flush = 1'b1;
                next_cycle();
                flush = 1'b0;
                // a flushed multiply must never offer a result
                k = 0;
                while (k < 80 && !res_req) begin
                    next_cycle();
                    k++;
                end
                if (res_req) begin
                    value_errors++;
                    $display("Flushed multiply still raised res_req at %0t", $time);
                end
            end else begin
                wait_level(1, 1'b1, "res_req rising");
                check_data(expv);
                // next issue waits while this result is held
                if (r.delay != 0 && i + 1 < rows.size()) begin
                    present(rows[i+1]);
                    presented = 1'b1;
                end
                for (int d = 0; d < r.delay; d++) begin
                    next_cycle();
                    check_data(expv);
                end
                res_ack = 1'b1;
                wait_level(1, 1'b0, "res_req falling");
                res_ack = 1'b0;
            end
        end
        repeat (3) next_cycle();
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/alu_core.sv
module alu_core import exec_alu_pkg::*; #(
    parameter int mul_bits_per_cycle = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            start,
    input  alu_operands_t   operands,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0]        a;
    logic [xlen-1:0]        b;
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic [xlen-1:0]        single_value;
    logic [31:0]            sra_word;
    logic                   div_by_zero;
    logic                   div_overflow;
    logic                   mul_start;
    logic                   mul_done;
    logic                   mul_wait;
    logic [xlen-1:0]        product;

    assign a  = operands.a;
    assign b  = operands.b;
    assign sa = operands.a;
    assign sb = operands.b;

    assign div_by_zero  = (b == '0);
    // most negative value over minus one
    assign div_overflow = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);

    // 32-bit arithmetic shift for word mode
    assign sra_word = $signed(a[31:0]) >>> b[5:0];

    always_comb begin
        case (operands.op)
            op_add:    single_value = a + b;
            op_sub:    single_value = a - b;
            op_pass_a: single_value = a;
            op_pass_b: single_value = b;
            op_xor:    single_value = a ^ b;
            op_or:     single_value = a | b;
            op_and:    single_value = a & b;
            op_sll:    single_value = a << b[5:0];
            op_srl:    single_value = a >> b[5:0];
            op_sra: begin
                if (operands.word) begin
                    single_value = {32'b0, sra_word};
                end else begin
                    single_value = sa >>> b[5:0];
                end
            end
            op_slt:    single_value = {63'b0, sa < sb};
            op_sltu:   single_value = {63'b0, a < b};
            op_eq:     single_value = {63'b0, a == b};
            op_ge:     single_value = {63'b0, sa >= sb};
            op_geu:    single_value = {63'b0, a >= b};
            op_div: begin
                if (div_by_zero) begin
                    single_value = '1;
                end else if (div_overflow) begin
                    single_value = a;
                end else begin
                    single_value = sa / sb;
                end
            end
            op_divu:   single_value = div_by_zero ? '1 : a / b;
            op_rem: begin
                if (div_by_zero) begin
                    single_value = a;
                end else if (div_overflow) begin
                    single_value = '0;
                end else begin
                    single_value = sa % sb;
                end
            end
            op_remu:   single_value = div_by_zero ? a : a % b;
            default:   single_value = '0;
        endcase
    end

    // multiply goes to the iterative unit, flush wins over a new start
    assign mul_start = start && (operands.op == op_mul) && !flush;

    shift_add_multiplier #(
        .mul_bits_per_cycle(mul_bits_per_cycle)
    ) u_mul (
        .clk        (clk),
        .arst_n     (arst_n),
        .mul_start  (mul_start),
        .mul_cancel (flush),
        .a          (a),
        .b          (b),
        .mul_done   (mul_done),
        .product    (product)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            mul_wait <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                busy     <= 1'b0;
                mul_wait <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
                if (operands.op == op_mul) begin
                    mul_wait <= 1'b1;
                end else begin
                    done <= 1'b1;
                end
            end else begin
                if (mul_wait && mul_done) begin
                    done     <= 1'b1;
                    mul_wait <= 1'b0;
                end
                // result handed over this cycle
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && operands.op != op_mul) begin
            result <= single_value;
        end else if (mul_wait && mul_done) begin
            result <= product;
        end
    end

    // operand_select must hold off while an operation is pending
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> !busy
    );

endmodule

// File: verilog/exec_alu_pkg.sv
package exec_alu_pkg;

    // data width
    localparam int xlen = 64;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_t;

    typedef enum logic {
        src_a_pc,
        src_a_rs1
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_imm,
        src_b_rs2,
        src_b_csr
    } src_b_t;

    // record carried by the issue channel
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] csr;
        logic [xlen-1:0] imm;
        alu_op_t         op;
        src_a_t          src_a;
        src_b_t          src_b;
        logic            word;
    } alu_issue_t;

    // formed operands handed to the processing part
    typedef struct packed {
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        alu_op_t         op;
        logic            word;
    } alu_operands_t;

endpackage

// File: verilog/exec_alu_top.sv
module exec_alu_top import exec_alu_pkg::*; #(
    parameter int mul_bits_per_cycle = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            issue_req,
    input  alu_issue_t      issue,
    output logic            issue_ack,
    output logic            res_req,
    output logic [xlen-1:0] res_data,
    input  logic            res_ack
);

    logic            start;
    logic            busy;
    logic            full;
    logic            done;
    alu_operands_t   operands;
    logic [xlen-1:0] result;

    operand_select u_operand_select (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue_req (issue_req),
        .issue     (issue),
        .busy      (busy),
        .full      (full),
        .issue_ack (issue_ack),
        .start     (start),
        .operands  (operands)
    );

    alu_core #(
        .mul_bits_per_cycle(mul_bits_per_cycle)
    ) u_alu_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .start    (start),
        .operands (operands),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    result_port u_result_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .done     (done),
        .result   (result),
        .res_ack  (res_ack),
        .full     (full),
        .res_req  (res_req),
        .res_data (res_data)
    );

endmodule

// File: verilog/operand_select.sv
module operand_select import exec_alu_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          issue_req,
    input  alu_issue_t    issue,
    input  logic          busy,
    input  logic          full,
    output logic          issue_ack,
    output logic          start,
    output alu_operands_t operands
);

    logic [xlen-1:0] a_next;
    logic [xlen-1:0] b_next;
    logic            accept;

    // new work only when the core and the output side are both free
    assign accept = issue_req && !issue_ack && !busy && !full;

    // operand a, word mode keeps only the low half of rs1
    always_comb begin
        if (issue.src_a == src_a_rs1) begin
            if (issue.word) begin
                a_next = {32'b0, issue.rs1[31:0]};
            end else begin
                a_next = issue.rs1;
            end
        end else begin
            a_next = issue.pc;
        end
    end

    always_comb begin
        case (issue.src_b)
            src_b_rs2: b_next = issue.rs2;
            src_b_csr: b_next = issue.csr;
            default:   b_next = issue.imm;
        endcase
    end

    // four-phase issue side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_ack <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                issue_ack <= 1'b1;
                start     <= 1'b1;
            end else if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0;
            end
        end
    end

    // operands held until the next accepted issue
    always_ff @(posedge clk) begin
        if (accept) begin
            operands.a    <= a_next;
            operands.b    <= b_next;
            operands.op   <= issue.op;
            operands.word <= issue.word;
        end
    end

    // sender must keep the record steady until it sees the ack
    a_issue_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (issue_req && !issue_ack) |=> (!issue_req || $stable(issue))
    );

endmodule

// File: verilog/result_port.sv
module result_port import exec_alu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            done,
    input  logic [xlen-1:0] result,
    input  logic            res_ack,
    output logic            full,
    output logic            res_req,
    output logic [xlen-1:0] res_data
);

    // four-phase output side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 1'b0;
            res_req <= 1'b0;
        end else begin
            if (done) begin
                full    <= 1'b1;
                res_req <= 1'b1;
            end else if (res_req && res_ack) begin
                res_req <= 1'b0;
            end else if (full && !res_req && !res_ack) begin
                // consumer has released its ack
                full <= 1'b0;
            end
        end
    end

    // held for as long as the consumer stalls
    always_ff @(posedge clk) begin
        if (done) begin
            res_data <= result;
        end
    end

    // consumer keeps its ack up until req has dropped
    a_ack_held_until_req_falls: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(res_ack) |-> !res_req
    );

    // the core must not overwrite a result still on offer
    a_no_done_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> !full
    );

endmodule

// File: verilog/shift_add_multiplier.sv
module shift_add_multiplier import exec_alu_pkg::*; #(
    parameter int mul_bits_per_cycle = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            mul_start,
    input  logic            mul_cancel,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic            mul_done,
    output logic [xlen-1:0] product
);

    localparam int steps = xlen / mul_bits_per_cycle;
    localparam int cnt_w = $clog2(steps) + 1;

    logic [xlen-1:0]  mcand;
    logic [xlen-1:0]  mplier;
    logic [xlen-1:0]  acc;
    logic [xlen-1:0]  mcand_cur;
    logic [xlen-1:0]  mplier_cur;
    logic [xlen-1:0]  acc_cur;
    logic [xlen-1:0]  partial;
    logic [cnt_w-1:0] cnt;
    logic             active;

    // first step runs straight off the inputs
    assign mcand_cur  = mul_start ? a : mcand;
    assign mplier_cur = mul_start ? b : mplier;
    assign acc_cur    = mul_start ? '0 : acc;

    // sum of the retired multiplier bits
    always_comb begin
        partial = '0;
        for (int j = 0; j < mul_bits_per_cycle; j++) begin
            if (mplier_cur[j]) begin
                partial = partial + (mcand_cur << j);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            mul_done <= 1'b0;
            cnt      <= '0;
        end else begin
            mul_done <= 1'b0;
            if (mul_cancel) begin
                active <= 1'b0;
                cnt    <= '0;
            end else if (mul_start) begin
                active <= 1'b1;
                cnt    <= cnt_w'(1);
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(steps - 1)) begin
                    active   <= 1'b0;
                    mul_done <= 1'b1;
                    cnt      <= '0;
                end
            end
        end
    end

    // only the low half of the product is kept
    always_ff @(posedge clk) begin
        if (mul_start || active) begin
            acc    <= acc_cur + partial;
            mcand  <= mcand_cur << mul_bits_per_cycle;
            mplier <= mplier_cur >> mul_bits_per_cycle;
        end
    end

    assign product = acc;

endmodule
